/* include/cbus_consts.svh */
`ifndef CBUS_CONSTS_SVH
`define CBUS_CONSTS_SVH

// bus widths in bits
`define CBUS_ADDR_W 32
`define CBUS_DATA_W 32

// words per icache line
`define LINE_WORDS 4

// cycles from accept to first beat
`define MEM_LATENCY 3

// memory depth in words
`define MEM_WORDS 1024

`endif

/* verilog/cbus_pkg.sv */
`include "cbus_consts.svh"

package cbus_pkg;

    typedef logic [3:0] cbus_len_t;   // beats minus one
    typedef logic [2:0] cbus_size_t;  // log2 of bytes per beat

    typedef struct packed {
        logic                       valid;
        logic                       is_write;
        cbus_size_t                 size;
        logic [`CBUS_ADDR_W-1:0]    addr;
        logic [`CBUS_DATA_W/8-1:0]  strobe;
        cbus_len_t                  len;
        logic [`CBUS_DATA_W-1:0]    data;
    } cbus_req_t;

    typedef struct packed {
        logic                       okay;  // one beat
        logic                       last;  // final beat of the burst
        logic [`CBUS_DATA_W-1:0]    data;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_busy,
        arb_judge
    } arb_state_t;

endpackage

/* verilog/cbus_if.sv */
`timescale 1ns/10ps

interface cbus_if;

    import cbus_pkg::*;

    cbus_req_t  req;
    cbus_resp_t resp;

    modport master (
        output req,
        input  resp
    );

    modport slave (
        input  req,
        output resp
    );

endinterface

/* verilog/cbus_arbiter.sv */
`timescale 1ns/10ps

module cbus_arbiter #(
    parameter int NUM_INPUTS = 2
) (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  cbus_pkg::cbus_req_t  [NUM_INPUTS-1:0]  ireqs,
    output cbus_pkg::cbus_resp_t [NUM_INPUTS-1:0]  iresps,
    cbus_if.master                                 mem
);

    import cbus_pkg::*;

    localparam int IDX_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    arb_state_t             state;
    logic [IDX_W-1:0]       index;   // held grant
    logic [IDX_W-1:0]       select;  // current winner

    // lowest index wins, so scan downwards
    always_comb begin
        select = '0;
        for (int i = NUM_INPUTS - 1; i >= 0; i--) begin
            if (ireqs[i].valid) begin
                select = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= arb_idle;
            index <= '0;
        end else begin
            unique case (state)
                arb_idle, arb_judge: begin
                    state <= ireqs[select].valid ? arb_busy : arb_idle;
                    index <= select;
                end
                arb_busy: begin
                    if (mem.resp.last) begin
                        state <= arb_judge;
                    end
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    always_comb begin
        if (state == arb_busy) begin
            mem.req = ireqs[index];
        end else begin
            mem.req = ireqs[select];  // new winner passes straight through
        end
    end

    always_comb begin
        iresps = '0;
        if (state == arb_busy) begin
            iresps[index] = mem.resp;
        end else begin
            iresps[select] = mem.resp;
        end
    end

    // beats only go to the one granted, still requesting master
    a_one_target: assert property (@(posedge clk) disable iff (resetn)
        mem.resp.okay |-> state == arb_busy && ireqs[index].valid);

    a_last_okay: assert property (@(posedge clk) disable iff (resetn)
        mem.resp.last |-> mem.resp.okay);

endmodule

/* verilog/icache_fill.sv */
`timescale 1ns/10ps

`include "cbus_consts.svh"

module icache_fill (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     miss,
    input  logic [`CBUS_ADDR_W-1:0]  miss_addr,
    output logic                     fill_valid,
    output logic [`CBUS_DATA_W-1:0]  fill_word,
    output logic                     fill_done,
    cbus_if.master                   bus
);

    import cbus_pkg::*;

    localparam int LINE_OFS = $clog2(`LINE_WORDS * `CBUS_DATA_W / 8);

    logic                     active;
    logic [`CBUS_ADDR_W-1:0]  line_addr;

    always_ff @(posedge clk) begin
        if (resetn) begin
            active <= 1'b0;
        end else if (!active && miss) begin
            active <= 1'b1;
        end else if (bus.resp.okay && bus.resp.last) begin
            active <= 1'b0;  // request drops after last
        end
    end

    always_ff @(posedge clk) begin
        if (!active && miss) begin
            line_addr <= {miss_addr[`CBUS_ADDR_W-1:LINE_OFS], {LINE_OFS{1'b0}}};
        end
    end

    always_comb begin
        bus.req          = '0;
        bus.req.valid    = active;
        bus.req.is_write = 1'b0;
        bus.req.size     = cbus_size_t'($clog2(`CBUS_DATA_W / 8));
        bus.req.addr     = line_addr;
        bus.req.len      = cbus_len_t'(`LINE_WORDS - 1);
    end

    assign fill_valid = bus.resp.okay;
    assign fill_word  = bus.resp.data;
    assign fill_done  = bus.resp.okay && bus.resp.last;

    a_no_miss_busy: assert property (@(posedge clk) disable iff (resetn)
        active |-> !miss);

endmodule

/* verilog/dcache_port.sv */
`timescale 1ns/10ps

`include "cbus_consts.svh"

module dcache_port (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       req,
    input  logic                       we,
    input  logic [`CBUS_ADDR_W-1:0]    addr,
    input  logic [`CBUS_DATA_W-1:0]    wdata,
    input  logic [`CBUS_DATA_W/8-1:0]  wstrb,
    output logic [`CBUS_DATA_W-1:0]    rdata,
    output logic                       done,
    cbus_if.master                     bus
);

    import cbus_pkg::*;

    logic                       active;
    logic                       we_q;
    logic [`CBUS_ADDR_W-1:0]    addr_q;
    logic [`CBUS_DATA_W-1:0]    wdata_q;
    logic [`CBUS_DATA_W/8-1:0]  wstrb_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= active && bus.resp.okay && bus.resp.last;
            if (!active && req) begin
                active <= 1'b1;  // later strobes ignored
            end else if (bus.resp.okay && bus.resp.last) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && req) begin
            we_q    <= we;
            addr_q  <= addr;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (active && bus.resp.okay && !we_q) begin
            rdata <= bus.resp.data;
        end
    end

    always_comb begin
        bus.req          = '0;
        bus.req.valid    = active;
        bus.req.is_write = we_q;
        bus.req.size     = cbus_size_t'($clog2(`CBUS_DATA_W / 8));
        bus.req.addr     = addr_q;
        bus.req.strobe   = we_q ? wstrb_q : '0;
        bus.req.len      = '0;  // single beat
        bus.req.data     = wdata_q;
    end

endmodule

/* verilog/cbus_sram.sv */
`timescale 1ns/10ps

`include "cbus_consts.svh"

module cbus_sram (
    input  logic   clk,
    input  logic   resetn,
    cbus_if.slave  bus
);

    import cbus_pkg::*;

    localparam int AW    = $clog2(`MEM_WORDS);
    localparam int OFS   = $clog2(`CBUS_DATA_W / 8);
    localparam int LAT_W = $clog2(`MEM_LATENCY + 1);

    typedef enum logic [1:0] {
        m_idle,
        m_wait,
        m_beat,
        m_cool
    } mem_state_t;

    mem_state_t              state;
    logic [LAT_W-1:0]        lat_cnt;
    cbus_len_t               beats_left;
    logic [AW-1:0]           waddr_q;
    logic                    wr_q;
    logic [`CBUS_DATA_W-1:0] mem [`MEM_WORDS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state      <= m_idle;
            lat_cnt    <= '0;
            beats_left <= '0;
        end else begin
            unique case (state)
                m_idle: begin
                    if (bus.req.valid) begin
                        state      <= (`MEM_LATENCY > 1) ? m_wait : m_beat;
                        lat_cnt    <= LAT_W'(`MEM_LATENCY - 1);
                        beats_left <= bus.req.len;
                    end
                end
                m_wait: begin
                    lat_cnt <= lat_cnt - 1'b1;
                    if (lat_cnt == LAT_W'(1)) begin
                        state <= m_beat;
                    end
                end
                m_beat: begin
                    beats_left <= beats_left - 1'b1;
                    if (beats_left == '0) begin
                        state <= m_cool;
                    end
                end
                default: begin
                    state <= m_idle;  // one dead cycle after last
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && bus.req.valid) begin
            waddr_q <= bus.req.addr[OFS +: AW];
            wr_q    <= bus.req.is_write;
        end else if (state == m_beat) begin
            waddr_q <= waddr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_beat && wr_q) begin
            for (int b = 0; b < `CBUS_DATA_W / 8; b++) begin
                if (bus.req.strobe[b]) begin
                    mem[waddr_q][8*b +: 8] <= bus.req.data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        bus.resp.okay = (state == m_beat);
        bus.resp.last = (state == m_beat) && (beats_left == '0);
        bus.resp.data = mem[waddr_q];
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (resetn)
        bus.req.valid |-> bus.req.addr[OFS-1:0] == '0);

endmodule

/* verilog/mem_subsys_top.sv */
`timescale 1ns/10ps

`include "cbus_consts.svh"

module mem_subsys_top (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       miss,
    input  logic [`CBUS_ADDR_W-1:0]    miss_addr,
    output logic                       fill_valid,
    output logic [`CBUS_DATA_W-1:0]    fill_word,
    output logic                       fill_done,
    input  logic                       dport_req,
    input  logic                       dport_we,
    input  logic [`CBUS_ADDR_W-1:0]    dport_addr,
    input  logic [`CBUS_DATA_W-1:0]    dport_wdata,
    input  logic [`CBUS_DATA_W/8-1:0]  dport_wstrb,
    output logic [`CBUS_DATA_W-1:0]    dport_rdata,
    output logic                       dport_done
);

    import cbus_pkg::*;

    cbus_if d_bus ();
    cbus_if i_bus ();
    cbus_if m_bus ();

    cbus_req_t  [1:0] reqs;
    cbus_resp_t [1:0] resps;

    assign reqs[0]    = d_bus.req;  // data port has priority
    assign reqs[1]    = i_bus.req;
    assign d_bus.resp = resps[0];
    assign i_bus.resp = resps[1];

    dcache_port u_dport (
        .clk    (clk),
        .resetn (resetn),
        .req    (dport_req),
        .we     (dport_we),
        .addr   (dport_addr),
        .wdata  (dport_wdata),
        .wstrb  (dport_wstrb),
        .rdata  (dport_rdata),
        .done   (dport_done),
        .bus    (d_bus.master)
    );

    icache_fill u_fill (
        .clk        (clk),
        .resetn     (resetn),
        .miss       (miss),
        .miss_addr  (miss_addr),
        .fill_valid (fill_valid),
        .fill_word  (fill_word),
        .fill_done  (fill_done),
        .bus        (i_bus.master)
    );

    cbus_arbiter #(
        .NUM_INPUTS (2)
    ) u_arb (
        .clk    (clk),
        .resetn (resetn),
        .ireqs  (reqs),
        .iresps (resps),
        .mem    (m_bus.master)
    );

    cbus_sram u_sram (
        .clk    (clk),
        .resetn (resetn),
        .bus    (m_bus.slave)
    );

endmodule

/* tb/tb_mem_subsys.sv */
`timescale 1ns/10ps

`include "cbus_consts.svh"

module tb_mem_subsys;

    localparam int TIMEOUT = 100;  // cycles per wait
    localparam int REGION  = 64;   // words touched by the tests
    localparam int LW      = `LINE_WORDS;

    logic                       clk;
    logic                       resetn;
    logic                       miss;
    logic [`CBUS_ADDR_W-1:0]    miss_addr;
    logic                       fill_valid;
    logic [`CBUS_DATA_W-1:0]    fill_word;
    logic                       fill_done;
    logic                       dport_req;
    logic                       dport_we;
    logic [`CBUS_ADDR_W-1:0]    dport_addr;
    logic [`CBUS_DATA_W-1:0]    dport_wdata;
    logic [`CBUS_DATA_W/8-1:0]  dport_wstrb;
    logic [`CBUS_DATA_W-1:0]    dport_rdata;
    logic                       dport_done;

    logic [`CBUS_DATA_W-1:0]    shadow [`MEM_WORDS];  // every write lands here too
    logic                       started = 1'b0;
    int                         errors = 0;
    int                         timeouts = 0;
    int                         cycle = 0;
    int                         dport_end;
    int                         fill_end;

    mem_subsys_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (resetn)
        !started |-> !dport_done && !fill_valid && !fill_done)
        else begin
            errors++;
            $display("outputs went active after reset before any stimulus");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (resetn)
        dport_done |=> !dport_done)
        else begin
            errors++;
            $display("dport_done stayed high for more than one cycle");
        end

    a_fill_done_word: assert property (@(posedge clk) disable iff (resetn)
        fill_done |-> fill_valid)
        else begin
            errors++;
            $display("fill_done came without a fill word");
        end

    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return {addr[15:0] ^ 16'h5a5a, ~addr[15:0] ^ addr[31:16]};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];  // strobed bytes only
        end
        return res;
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic dport_access(input string name, input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] wstrb);
        int n;
        int idx;
        idx = (addr >> 2) % `MEM_WORDS;
        @(negedge clk);
        started     = 1'b1;
        dport_req   = 1'b1;
        dport_we    = we;
        dport_addr  = addr;
        dport_wdata = wdata;
        dport_wstrb = wstrb;
        if (we) shadow[idx] = merge_bytes(shadow[idx], wdata, wstrb);
        @(negedge clk);
        dport_req = 1'b0;
        for (n = 0; n < TIMEOUT && !dport_done; n++) begin
            @(negedge clk);
        end
        if (!dport_done) begin
            timeouts++;
            $display("timeout in %s: data port access never finished", name);
        end else if (!we) begin
            assert (dport_rdata === shadow[idx])
                else value_mismatch(name, shadow[idx], dport_rdata);
        end
        dport_end = cycle;
    endtask

    task automatic line_fill(input string name, input logic [31:0] addr);
        int n;
        int k;
        int base;
        k    = 0;
        base = ((addr >> 2) & ~(LW - 1)) % `MEM_WORDS;  // aligned line start
        @(negedge clk);
        started   = 1'b1;
        miss      = 1'b1;
        miss_addr = addr;
        @(negedge clk);
        miss = 1'b0;
        for (n = 0; n < TIMEOUT && k < LW; n++) begin
            if (fill_valid) begin
                assert (fill_word === shadow[base + k])
                    else value_mismatch(name, shadow[base + k], fill_word);
                assert (fill_done === (k == LW - 1))
                    else value_mismatch({name, " fill_done"}, k == LW - 1, fill_done);
                k++;
            end
            if (k < LW) @(negedge clk);
        end
        if (k < LW) begin
            timeouts++;
            $display("timeout in %s: line fill returned only %0d words", name, k);
        end
        fill_end = cycle;
    endtask

    initial begin
        int          seed;
        int          op;
        logic [31:0] a;
        seed        = $urandom(82);
        resetn      = 1'b1;
        miss        = 1'b0;
        miss_addr   = '0;
        dport_req   = 1'b0;
        dport_we    = 1'b0;
        dport_addr  = '0;
        dport_wdata = '0;
        dport_wstrb = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        repeat (5) @(negedge clk);  // idle window after reset

        for (int i = 0; i < REGION; i++) begin
            dport_access("prefill", 1'b1, i * 4, fill_pattern(i * 4), 4'hf);
        end

        dport_access("write_read", 1'b1, 32'h20, 32'hdeadbeef, 4'hf);
        dport_access("write_read", 1'b0, 32'h20, '0, '0);

        dport_access("partial_strobe", 1'b1, 32'h24, 32'h11223344, 4'hf);
        dport_access("partial_strobe", 1'b1, 32'h24, 32'haabbccdd, 4'b0101);
        dport_access("partial_strobe", 1'b0, 32'h24, '0, '0);

        for (int i = 0; i < LW; i++) begin
            dport_access("line_fill", 1'b1, 32'h40 + i * 4, $urandom, 4'hf);
        end
        line_fill("line_fill", 32'h48);  // unaligned miss inside the line

        fork
            dport_access("concurrent", 1'b1, 32'h84, 32'hcafef00d, 4'hf);
            line_fill("concurrent", 32'h80);
        join
        assert (dport_end < fill_end) else begin
            errors++;
            $display("data port did not finish before the fill in the concurrent test");
        end

        for (int i = 0; i < 50; i++) begin
            op = $urandom_range(0, 2);
            a  = $urandom_range(0, REGION * 4 - 1);
            case (op)
                0: dport_access("random", 1'b1, a & ~32'h3, $urandom, $urandom_range(1, 15));
                1: dport_access("random", 1'b0, a & ~32'h3, '0, '0);
                default: line_fill("random", a);
            endcase
        end

        repeat (4) @(negedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
verilog/cbus_pkg.sv
verilog/cbus_if.sv
verilog/cbus_arbiter.sv
verilog/icache_fill.sv
verilog/dcache_port.sv
verilog/cbus_sram.sv
verilog/mem_subsys_top.sv
tb/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - include
    files:
      - verilog/cbus_pkg.sv
      - verilog/cbus_if.sv
      - verilog/cbus_arbiter.sv
      - verilog/icache_fill.sv
      - verilog/dcache_port.sv
      - verilog/cbus_sram.sv
      - verilog/mem_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_mem_subsys.sv
